/* hw/ternary_pkg.sv */
`default_nettype none

package ternary_pkg;

    // array geometry
    localparam int trits_per_byte = 5;
    localparam int slices = 3;
    localparam int rows = trits_per_byte * slices;
    localparam int cells = rows * slices;
    localparam int slice_bits = $clog2(slices);
    localparam int cell_bits = $clog2(cells);

    // accumulator width and the byte window returned on reads
    localparam int acc_width = 17;
    localparam int out_shift = 8;

    // 3^5 - 1, anything above decodes to zero weights
    localparam int max_code = 242;

    // wishbone word addresses
    localparam logic [1:0] addr_pair = 2'd0;
    localparam logic [1:0] addr_readout = 2'd1;
    localparam logic [1:0] addr_result = 2'd2;

    // one tile: row i uses bit i of each mask, column j uses act[j]
    typedef struct packed {
        logic [rows-1:0] zero_mask;
        logic [rows-1:0] sign_mask;
        logic [slices-1:0][7:0] act;
    } tile_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [1:0] adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // weight byte sits in the upper half of the bus word
    typedef struct packed {
        logic [7:0] weight;
        logic [7:0] act;
    } pair_t;

endpackage

`default_nettype wire

/* hw/trit_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module trit_unpacker (
    input wire [7:0] code,
    output logic [4:0] zero_mask,
    output logic [4:0] sign_mask
);

    logic [7:0] rest;
    logic [1:0] digit;

    // base-3 digits, least significant first
    // trit k lands on lane 4-k, digit 1 is +1 and digit 2 is -1
    always_comb begin
        rest = code;
        digit = 2'd0;
        zero_mask = '1;
        sign_mask = '0;
        if (code <= 8'(ternary_pkg::max_code)) begin
            for (int k = 0; k < ternary_pkg::trits_per_byte; k++) begin
                digit = 2'(rest % 8'd3);
                zero_mask[ternary_pkg::trits_per_byte-1-k] = (digit == 2'd0);
                sign_mask[ternary_pkg::trits_per_byte-1-k] = (digit == 2'd2);
                rest = rest / 8'd3;
            end
        end
        // codes 243..255 keep the all-zero weights set above
    end

endmodule

`default_nettype wire

/* hw/bus_front.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_front (
    input wire clk,
    input wire reset,
    input wire ternary_pkg::wb_req_t wb_req,
    output ternary_pkg::wb_rsp_t wb_rsp,
    input wire busy,
    input wire [7:0] result,
    output logic pair_valid,
    output ternary_pkg::pair_t pair,
    output logic readout,
    output logic pop
);

    logic ack;
    logic req;
    logic is_readout;
    logic take;

    // ignore the request still held during our own ack cycle
    assign req = wb_req.cyc && wb_req.stb && !ack;
    assign is_readout = req && wb_req.we && (wb_req.adr == ternary_pkg::addr_readout);

    // a readout waits here while the array is still applying a tile
    assign take = req && (!is_readout || !busy);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            pair_valid <= 1'b0;
            readout <= 1'b0;
            pop <= 1'b0;
        end else begin
            ack <= take;
            pair_valid <= take && wb_req.we && (wb_req.adr == ternary_pkg::addr_pair);
            readout <= take && is_readout;
            pop <= take && !wb_req.we && (wb_req.adr == ternary_pkg::addr_result);
        end
    end

    // bus word of each accepted access
    always_ff @(posedge clk) begin
        if (take) begin
            pair <= ternary_pkg::pair_t'(wb_req.dat);
        end
    end

    // pop marks the ack of a result read and every other access returns zero
    always_comb begin
        wb_rsp.ack = ack;
        wb_rsp.dat = pop ? result : 8'h00;
    end

endmodule

`default_nettype wire

/* hw/tile_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_collector (
    input wire clk,
    input wire reset,
    input wire pair_valid,
    input wire ternary_pkg::pair_t pair,
    input wire readout,
    output logic tile_valid,
    output ternary_pkg::tile_t tile
);

    localparam int tpb = ternary_pkg::trits_per_byte;

    logic [ternary_pkg::slice_bits-1:0] slice;
    logic [tpb-1:0] zero_mask;
    logic [tpb-1:0] sign_mask;
    logic last_slice;

    trit_unpacker trit_unpacker_inst (
        .code(pair.weight),
        .zero_mask(zero_mask),
        .sign_mask(sign_mask)
    );

    assign last_slice = (slice == ternary_pkg::slice_bits'(ternary_pkg::slices - 1));

    // slice counter, a readout drops whatever partial tile was collected
    always_ff @(posedge clk) begin
        if (reset || readout) begin
            slice <= '0;
            tile_valid <= 1'b0;
        end else begin
            tile_valid <= pair_valid && last_slice;
            if (pair_valid) begin
                slice <= last_slice ? '0 : slice + 1'b1;
            end
        end
    end

    // pair k fills rows 5k..5k+4 and column k
    // the array latches the tile on tile_valid, before the next pair can land
    always_ff @(posedge clk) begin
        if (pair_valid) begin
            tile.zero_mask[slice*tpb +: tpb] <= zero_mask;
            tile.sign_mask[slice*tpb +: tpb] <= sign_mask;
            tile.act[slice] <= pair.act;
        end
    end

endmodule

`default_nettype wire

/* hw/mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_array (
    input wire clk,
    input wire reset,
    input wire tile_valid,
    input wire ternary_pkg::tile_t tile,
    input wire readout,
    output logic busy,
    output logic [ternary_pkg::cells-1:0][ternary_pkg::acc_width-1:0] accumulators
);

    localparam int aw = ternary_pkg::acc_width;
    localparam int slices = ternary_pkg::slices;

    ternary_pkg::tile_t cur;
    logic running;
    logic [ternary_pkg::slice_bits-1:0] col;
    logic [7:0] act_sel;
    logic [aw-1:0] addend;

    // activation of the column being applied, sign extended
    assign act_sel = cur.act[col];
    assign addend = {{(aw - 8){act_sel[7]}}, act_sel};

    // tile_valid counts too, so a readout cannot slip in before column 0
    assign busy = tile_valid || running;

    // column sequencer, one column per cycle after tile_valid
    always_ff @(posedge clk) begin
        if (reset || readout) begin
            running <= 1'b0;
            col <= '0;
        end else if (tile_valid) begin
            running <= 1'b1;
            col <= '0;
        end else if (running) begin
            if (col == ternary_pkg::slice_bits'(slices - 1)) begin
                running <= 1'b0;
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_valid) begin
            cur <= tile;
        end
    end

    // cell (row i, column j) sits at i*3 + j
    always_ff @(posedge clk) begin
        if (reset || readout) begin
            accumulators <= '0;
        end else if (running) begin
            for (int i = 0; i < ternary_pkg::rows; i++) begin
                if (!cur.zero_mask[i]) begin
                    if (cur.sign_mask[i]) begin
                        accumulators[i*slices+col] <= accumulators[i*slices+col] - addend;
                    end else begin
                        accumulators[i*slices+col] <= accumulators[i*slices+col] + addend;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/readout_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module readout_queue (
    input wire clk,
    input wire reset,
    input wire readout,
    input wire [ternary_pkg::cells-1:0][ternary_pkg::acc_width-1:0] accumulators,
    input wire pop,
    output logic [7:0] result
);

    logic [ternary_pkg::cells-1:0][ternary_pkg::acc_width-1:0] queue;
    logic [ternary_pkg::cell_bits-1:0] index;

    // snapshot taken in the same cycle the array clears
    always_ff @(posedge clk) begin
        if (reset) begin
            queue <= '0;
        end else if (readout) begin
            queue <= accumulators;
        end
    end

    // read order is row*3 + column, wrapping after the last cell
    always_ff @(posedge clk) begin
        if (reset || readout) begin
            index <= '0;
        end else if (pop) begin
            if (index == ternary_pkg::cell_bits'(ternary_pkg::cells - 1)) begin
                index <= '0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

    assign result = queue[index][ternary_pkg::out_shift +: 8];

endmodule

`default_nettype wire

/* hw/ternary_matmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ternary_matmul_top (
    input wire clk,
    input wire reset,
    input wire ternary_pkg::wb_req_t wb_req,
    output ternary_pkg::wb_rsp_t wb_rsp
);

    logic pair_valid;
    ternary_pkg::pair_t pair;
    logic readout;
    logic pop;
    logic busy;
    logic [7:0] result;
    logic tile_valid;
    ternary_pkg::tile_t tile;
    logic [ternary_pkg::cells-1:0][ternary_pkg::acc_width-1:0] accumulators;

    bus_front bus_front_inst (
        .clk(clk),
        .reset(reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .busy(busy),
        .result(result),
        .pair_valid(pair_valid),
        .pair(pair),
        .readout(readout),
        .pop(pop)
    );

    tile_collector tile_collector_inst (
        .clk(clk),
        .reset(reset),
        .pair_valid(pair_valid),
        .pair(pair),
        .readout(readout),
        .tile_valid(tile_valid),
        .tile(tile)
    );

    mac_array mac_array_inst (
        .clk(clk),
        .reset(reset),
        .tile_valid(tile_valid),
        .tile(tile),
        .readout(readout),
        .busy(busy),
        .accumulators(accumulators)
    );

    readout_queue readout_queue_inst (
        .clk(clk),
        .reset(reset),
        .readout(readout),
        .accumulators(accumulators),
        .pop(pop),
        .result(result)
    );

endmodule

`default_nettype wire

/* verification/ternary_matmul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ternary_matmul_tb;

    localparam int max_ops = 64;
    localparam int ack_timeout = 50;

    logic clk;
    logic reset;
    ternary_pkg::wb_req_t wb_req;
    ternary_pkg::wb_rsp_t wb_rsp;

    // op[31:28] adr[27:24] data[23:8] expected[7:0]
    logic [31:0] ops [max_ops];
    int errors;
    int timeouts;

    ternary_matmul_top ternary_matmul_top_inst (
        .clk(clk),
        .reset(reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one classic wishbone access held until ack or until the timeout runs out
    task automatic bus_access(input logic we, input logic [1:0] adr,
                              input logic [15:0] wdata, output logic [7:0] rdata);
        int waited;
        logic got;
        waited = 0;
        got = 1'b0;
        rdata = 8'h00;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdata;
        while (!got && waited < ack_timeout) begin
            @(posedge clk);
            if (wb_rsp.ack) begin
                got = 1'b1;
                rdata = wb_rsp.dat;
            end
            waited++;
        end
        // release the bus on the edge that closed the ack cycle
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we <= 1'b0;
        if (!got) begin
            timeouts++;
            $display("no acknowledge within %0d cycles for an access to address %0d",
                     ack_timeout, adr);
        end
    endtask

    initial begin
        logic [3:0] op;
        logic [1:0] adr;
        logic [15:0] data;
        logic [7:0] expected;
        logic [7:0] rdata;
        int count;
        int gap;
        errors = 0;
        timeouts = 0;
        void'($urandom(61480));
        wb_req <= '0;
        reset <= 1'b1;
        for (int i = 0; i < max_ops; i++) begin
            ops[i] = '0;
        end
        $readmemh("verification/ternary_matmul_vectors.txt", ops);
        if (ops[0][31:28] == 4'h0) begin
            errors++;
            $display("the vector file holds no operations");
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // op 1 writes once and op 2 reads data times with the same expected byte
        for (int n = 0; n < max_ops && ops[n][31:28] != 4'h0; n++) begin
            op = ops[n][31:28];
            adr = ops[n][25:24];
            data = ops[n][23:8];
            expected = ops[n][7:0];
            count = (op == 4'h2) ? int'(data) : 1;
            for (int r = 0; r < count; r++) begin
                gap = int'($urandom % 4);
                repeat (gap) @(posedge clk);
                bus_access(op == 4'h1, adr, data, rdata);
                if (op == 4'h2 && rdata !== expected) begin
                    errors++;
                    $display("** Error: wb_rsp.dat vector %0d read %0d: expected %h, got %h",
                             n, r, expected, rdata);
                end
            end
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/ternary_matmul_vectors.txt */
// op adr data(4 hex) expected(2 hex), op 1 = write, op 2 = read repeated data times
// pair write data is the weight byte then the activation byte, adr 1 write = readout
22000300
20000100
// one tile, codes 1, 2 and 121
10017F00
10024000
10797000
11000000
22001B00
220003FF
22000F00
// three tiles summed, then a partial tile that the readout drops
10798000
10F28000
10F28000
10798100
10F28100
10F28100
10798000
10008000
10F28000
10797F00
11000000
21000100
22000FFE
22000F00
22000F01
// read 46 wraps to the first entry
220001FE
// codes 244 and 255 carry no weight
10F48000
10FF8000
10798000
11000000
22001E00
22000FFF

/* ternary_matmul.f */
hw/ternary_pkg.sv
hw/trit_unpacker.sv
hw/bus_front.sv
hw/tile_collector.sv
hw/mac_array.sv
hw/readout_queue.sv
hw/ternary_matmul_top.sv
verification/ternary_matmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ternary_matmul testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ternary_matmul_tb -f ternary_matmul.f \
    -o ternary_matmul_sim
./obj_dir/ternary_matmul_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
